//--- simd_slice.f
+incdir+tests
source/simd_pkg.sv
source/simd_operand_decode.sv
source/simd_lane_pipe.sv
source/simd_lane_alu.sv
source/simd_result_pack.sv
source/simd_slice_top.sv
tests/simd_slice_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing
TOP       = simd_slice_tb
FILELIST  = simd_slice.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/simd_slice_vectors.svh
// Directed stimulus rows with expected result, status and extension bit
// Row fields in order are op, format, vectorial, op_a, op_b, tag, result, status {pos, neg}, ext bit
task automatic fill_table();
  // Scalar W32
  add_row(simd_pkg::ADD, simd_pkg::W32, 0, 32'h0000_0005, 32'h0000_0003, 4'h0,
          32'h0000_0008, 2'b00, 1'b0);
  add_row(simd_pkg::ADD, simd_pkg::W32, 0, 32'h7FFF_FFFF, 32'h0000_0001, 4'h1,
          32'h8000_0000, 2'b10, 1'b1);
  add_row(simd_pkg::SUB, simd_pkg::W32, 0, 32'h8000_0000, 32'h0000_0001, 4'h2,
          32'h7FFF_FFFF, 2'b01, 1'b0);
  add_row(simd_pkg::MIN, simd_pkg::W32, 0, 32'hFFFF_FFFE, 32'h0000_0003, 4'h3,
          32'hFFFF_FFFE, 2'b00, 1'b1);
  add_row(simd_pkg::MAX, simd_pkg::W32, 0, 32'hFFFF_FFFE, 32'h0000_0003, 4'h4,
          32'h0000_0003, 2'b00, 1'b0);
  // Scalar W16, upper bits ignored on the way in
  add_row(simd_pkg::ADD, simd_pkg::W16, 0, 32'h1234_7FFF, 32'hABCD_0001, 4'h5,
          32'hFFFF_8000, 2'b10, 1'b1);
  add_row(simd_pkg::SUB, simd_pkg::W16, 0, 32'h0000_0010, 32'h0000_0020, 4'h6,
          32'hFFFF_FFF0, 2'b00, 1'b1);
  add_row(simd_pkg::MIN, simd_pkg::W16, 0, 32'hFFFF_0005, 32'h0000_8000, 4'h7,
          32'hFFFF_8000, 2'b00, 1'b1);
  add_row(simd_pkg::MAX, simd_pkg::W16, 0, 32'hFFFF_0005, 32'h0000_8000, 4'h8,
          32'h0000_0005, 2'b00, 1'b0);
  // Scalar W8
  add_row(simd_pkg::ADD, simd_pkg::W8, 0, 32'hAAAA_AA7F, 32'h5555_5501, 4'h9,
          32'hFFFF_FF80, 2'b10, 1'b1);
  add_row(simd_pkg::SUB, simd_pkg::W8, 0, 32'h0000_0080, 32'h0000_0001, 4'hA,
          32'h0000_007F, 2'b01, 1'b0);
  add_row(simd_pkg::MIN, simd_pkg::W8, 0, 32'h0000_0003, 32'h0000_00FD, 4'hB,
          32'hFFFF_FFFD, 2'b00, 1'b1);
  add_row(simd_pkg::MAX, simd_pkg::W8, 0, 32'h1234_5610, 32'h0000_0020, 4'hC,
          32'h0000_0020, 2'b00, 1'b0);
  // Vectorial W8, no carry between bytes
  add_row(simd_pkg::ADD, simd_pkg::W8, 1, 32'h0102_0304, 32'h1020_3040, 4'hD,
          32'h1122_3344, 2'b00, 1'b0);
  add_row(simd_pkg::ADD, simd_pkg::W8, 1, 32'hFF7F_80FF, 32'h0101_FF01, 4'hE,
          32'h0080_7F00, 2'b11, 1'b0);
  add_row(simd_pkg::SUB, simd_pkg::W8, 1, 32'h0A14_1E28, 32'h0102_0304, 4'hF,
          32'h0912_1B24, 2'b00, 1'b0);
  add_row(simd_pkg::MAX, simd_pkg::W8, 1, 32'h807F_01FF, 32'h0000_02FE, 4'h0,
          32'h007F_02FF, 2'b00, 1'b1);
  add_row(simd_pkg::MIN, simd_pkg::W8, 1, 32'h807F_01FF, 32'h0000_02FE, 4'h1,
          32'h8000_01FE, 2'b00, 1'b1);
  // Vectorial W16 and W32
  add_row(simd_pkg::ADD, simd_pkg::W16, 1, 32'h7FFF_0001, 32'h0001_FFFF, 4'h2,
          32'h8000_0000, 2'b10, 1'b0);
  add_row(simd_pkg::SUB, simd_pkg::W16, 1, 32'h0005_8000, 32'h0007_0001, 4'h3,
          32'hFFFE_7FFF, 2'b01, 1'b0);
  add_row(simd_pkg::MIN, simd_pkg::W16, 1, 32'h8000_1234, 32'h7FFF_1235, 4'h4,
          32'h8000_1234, 2'b00, 1'b0);
  add_row(simd_pkg::ADD, simd_pkg::W32, 1, 32'h0000_00FF, 32'h0000_0001, 4'h5,
          32'h0000_0100, 2'b00, 1'b0);
endtask

//--- tests/simd_slice_tb.sv
// Testbench for the SIMD slice with directed table, random rows, back-pressure and flush
module simd_slice_tb;

  localparam int NUM_RANDOM = 20;
  localparam int LATENCY    = simd_pkg::NUM_PIPE_REGS;

  typedef struct packed {
    simd_pkg::op_e     op;
    simd_pkg::fmt_e    fmt;
    logic              vec;
    simd_pkg::word_t   a;
    simd_pkg::word_t   b;
    simd_pkg::tag_t    tag;
    simd_pkg::word_t   res;
    simd_pkg::status_t st;
    logic              ext;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_n_i, flush_i, in_valid_i, in_ready_o, vectorial_i;
  logic out_valid_o, out_ready_i, ext_bit_o, busy_o;
  simd_pkg::word_t   op_a_i, op_b_i, result_o;
  simd_pkg::op_e     op_i;
  simd_pkg::fmt_e    fmt_i;
  simd_pkg::tag_t    tag_i, tag_o;
  simd_pkg::status_t status_o;

  row_t   rows [$];
  row_t   exp_q [$];    // Results still owed by the DUT, oldest first
  int     accept_q [$]; // Acceptance edge of each owed result
  int     errors = 0;
  int     cycles = 0;
  int     cycle_limit = 1000000;
  int     seed = 22861;
  int     ready_mode = 1; // 0 low, 1 high, 2 random
  bit     check_latency = 1'b0;

  simd_slice_top u_simd_slice_top (
    .clk_i, .rst_n_i, .flush_i, .in_valid_i, .in_ready_o, .op_a_i, .op_b_i,
    .op_i, .fmt_i, .vectorial_i, .tag_i, .out_valid_o, .out_ready_i,
    .result_o, .status_o, .ext_bit_o, .tag_o, .busy_o
  );

  always #50 clk_i = ~clk_i;

  // --------------------
  // Helpers
  // --------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic add_row(input simd_pkg::op_e op, input simd_pkg::fmt_e fmt, input logic vec,
                         input simd_pkg::word_t a, input simd_pkg::word_t b,
                         input simd_pkg::tag_t tag, input simd_pkg::word_t res,
                         input simd_pkg::status_t st, input logic ext);
    rows.push_back('{op, fmt, vec, a, b, tag, res, st, ext});
  endtask

  `include "simd_slice_vectors.svh"

  // Reference behavior with element-wise signed op, wrap and sign fill above the elements
  function automatic row_t expected_row(input row_t r);
    row_t            o;
    int              w, n;
    longint          ea, eb, ev, maxv, minv;
    simd_pkg::word_t mask, elem_a, elem_b, elem0;
    o = r;
    w = (r.fmt == simd_pkg::W8) ? 8 : (r.fmt == simd_pkg::W16) ? 16 : 32;
    n = r.vec ? 32 / w : 1;
    mask = (w == 32) ? 32'hFFFF_FFFF : ((32'd1 << w) - 1);
    maxv = (longint'(1) << (w - 1)) - 1;
    minv = -(longint'(1) << (w - 1));
    o.res = '0;
    o.st  = '0;
    elem0 = '0;
    for (int i = 0; i < n; i++) begin
      elem_a = (r.a >> (i * w)) & mask;
      elem_b = (r.b >> (i * w)) & mask;
      ea = elem_a[w-1] ? longint'(elem_a) - (longint'(1) << w) : longint'(elem_a);
      eb = elem_b[w-1] ? longint'(elem_b) - (longint'(1) << w) : longint'(elem_b);
      case (r.op)
        simd_pkg::ADD: ev = ea + eb;
        simd_pkg::SUB: ev = ea - eb;
        simd_pkg::MIN: ev = (ea < eb) ? ea : eb;
        default:       ev = (ea < eb) ? eb : ea;
      endcase
      if (ev > maxv) o.st[1] = 1'b1;
      if (ev < minv) o.st[0] = 1'b1;
      if (i == 0) elem0 = simd_pkg::word_t'(ev) & mask;
      o.res |= (simd_pkg::word_t'(ev) & mask) << (i * w);
    end
    o.ext = elem0[w-1];
    if (n * w < 32 && o.ext) begin
      o.res |= ~((32'd1 << (n * w)) - 1);
    end
    return o;
  endfunction

  task automatic drive_ready();
    logic [31:0] rnd;
    rnd = $random(seed);
    out_ready_i = (ready_mode == 2) ? rnd[0] : (ready_mode == 1);
  endtask

  // Holds one row on the inputs until the DUT takes it
  task automatic send_row(input row_t r, input bit expect_out);
    bit accepted;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk_i);
      #10;
      drive_ready();
      in_valid_i  = 1'b1;
      op_i        = r.op;
      fmt_i       = r.fmt;
      vectorial_i = r.vec;
      op_a_i      = r.a;
      op_b_i      = r.b;
      tag_i       = r.tag;
      @(negedge clk_i);
      if (in_ready_o) begin
        accepted = 1'b1;
        if (expect_out) begin
          exp_q.push_back(r);
          accept_q.push_back(cycles);
        end
      end else if (check_latency) begin
        errors++;
        $display("Input stalled at %0t although the output is always ready", $time);
      end
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    #10;
    drive_ready();
    in_valid_i = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wait_drain();
    do begin
      idle_cycle();
    end while (exp_q.size() != 0 || busy_o);
  endtask

  // --------------------
  // Monitor and timeout
  // --------------------
  always @(posedge clk_i) begin : monitor
    row_t exp_row;
    int   acc;
    if (rst_n_i && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected result with tag %h at time %0t", tag_o, $time);
      end else begin
        exp_row = exp_q.pop_front();
        acc     = accept_q.pop_front();
        check_value("tag_o", 32'(exp_row.tag), 32'(tag_o));
        check_value("result_o", exp_row.res, result_o);
        check_value("status_o", 32'(exp_row.st), 32'(status_o));
        check_value("ext_bit_o", 32'(exp_row.ext), 32'(ext_bit_o));
        if (check_latency) check_value("latency", LATENCY, cycles - acc);
      end
    end
  end

  always @(posedge clk_i) begin : timeout
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout, run did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  // --------------------
  // Sequence
  // --------------------
  initial begin : main
    row_t        r;
    logic [31:0] rnd;
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    op_a_i      = '0;
    op_b_i      = '0;
    op_i        = simd_pkg::ADD;
    fmt_i       = simd_pkg::W32;
    vectorial_i = 1'b0;
    tag_i       = '0;
    fill_table();
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd   = $random(seed);
      r     = '0;
      r.op  = simd_pkg::op_e'(rnd[1:0]);
      r.fmt = simd_pkg::fmt_e'(rnd[7:4] % 3);
      r.vec = rnd[8];
      r.a   = $random(seed);
      r.b   = $random(seed);
      r.tag = simd_pkg::tag_t'(rows.size());
      rows.push_back(expected_row(r));
    end
    cycle_limit = 4 * (2 * rows.size() + 3) + 50;

    repeat (4) @(posedge clk_i);
    #10 rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("out_valid_o", 0, 32'(out_valid_o));
    check_value("busy_o", 0, 32'(busy_o));
    check_value("in_ready_o", 1, 32'(in_ready_o));

    // Back to back with the output always ready
    check_latency = 1'b1;
    foreach (rows[i]) send_row(rows[i], 1'b1);
    wait_drain();
    check_latency = 1'b0;

    // Same rows under random back-pressure
    ready_mode = 2;
    foreach (rows[i]) send_row(rows[i], 1'b1);
    ready_mode = 1;
    wait_drain();

    // Fill the pipeline with the output stalled, then flush it
    ready_mode = 0;
    send_row(rows[0], 1'b0);
    send_row(rows[1], 1'b0);
    idle_cycle();
    check_value("in_ready_o", 0, 32'(in_ready_o));
    check_value("busy_o", 1, 32'(busy_o));
    @(posedge clk_i);
    #10 flush_i = 1'b1;
    @(posedge clk_i);
    #10 flush_i = 1'b0;
    ready_mode = 1;
    repeat (3) begin
      idle_cycle();
      check_value("out_valid_o", 0, 32'(out_valid_o));
    end
    check_value("busy_o", 0, 32'(busy_o));
    send_row(rows[2], 1'b1);
    wait_drain();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- source/simd_slice_top.sv
// Top level of the SIMD slice wiring operand decode, four execute lanes and result packer
module simd_slice_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  simd_pkg::word_t   op_a_i,
  input  simd_pkg::word_t   op_b_i,
  input  simd_pkg::op_e     op_i,
  input  simd_pkg::fmt_e    fmt_i,
  input  logic              vectorial_i,
  input  simd_pkg::tag_t    tag_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output simd_pkg::word_t   result_o,
  output simd_pkg::status_t status_o,
  output logic              ext_bit_o,
  output simd_pkg::tag_t    tag_o,
  output logic              busy_o
);

  localparam int unsigned L1_W = simd_pkg::lane_width(1);
  localparam int unsigned L2_W = simd_pkg::lane_width(2);
  localparam int unsigned L3_W = simd_pkg::lane_width(3);

  logic                 accept_valid;
  simd_pkg::lane_mask_t lane_valid, lane_out_ready, lane_busy;
  simd_pkg::word_t      lane0_a, lane0_b, lane0_res;
  logic [L1_W-1:0]      lane1_a, lane1_b, lane1_res;
  logic [L2_W-1:0]      lane2_a, lane2_b, lane2_res;
  logic [L3_W-1:0]      lane3_a, lane3_b, lane3_res;
  simd_pkg::status_t    lane0_status, lane1_status, lane2_status, lane3_status;
  simd_pkg::aux_t       in_aux, out_aux;

  // Upper lanes load only when lane 0 takes the instruction
  assign accept_valid = in_valid_i & in_ready_o;

  // --------------------
  // Input side
  // --------------------
  simd_operand_decode u_simd_operand_decode (
    .in_valid_i   (accept_valid),
    .vectorial_i  (vectorial_i),
    .fmt_i        (fmt_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .lane_valid_o (lane_valid),
    .lane0_a_o    (lane0_a),
    .lane0_b_o    (lane0_b),
    .lane1_a_o    (lane1_a),
    .lane1_b_o    (lane1_b),
    .lane2_a_o    (lane2_a),
    .lane2_b_o    (lane2_b),
    .lane3_a_o    (lane3_a),
    .lane3_b_o    (lane3_b),
    .aux_o        (in_aux)
  );

  // --------------------
  // Lanes
  // --------------------
  simd_lane_alu #(.LANE_W(simd_pkg::lane_width(0))) u_lane0 ( // Carries tag and aux
    .clk_i, .rst_n_i, .flush_i, .fmt_i, .op_i, .tag_i,
    .in_valid_i  (lane_valid[0]),     .in_ready_o  (in_ready_o),
    .a_i         (lane0_a),           .b_i         (lane0_b),
    .aux_i       (in_aux),            .out_valid_o (out_valid_o),
    .out_ready_i (lane_out_ready[0]), .result_o    (lane0_res),
    .status_o    (lane0_status),      .tag_o       (tag_o),
    .aux_o       (out_aux),           .busy_o      (lane_busy[0])
  );

  simd_lane_alu #(.LANE_W(L1_W)) u_lane1 (
    .clk_i, .rst_n_i, .flush_i, .fmt_i, .op_i,
    .in_valid_i  (lane_valid[1]),     .in_ready_o  (),
    .a_i         (lane1_a),           .b_i         (lane1_b),
    .tag_i       ('0),                .aux_i       ('0),
    .out_valid_o (),                  .out_ready_i (lane_out_ready[1]),
    .result_o    (lane1_res),         .status_o    (lane1_status),
    .tag_o       (),                  .aux_o       (),
    .busy_o      (lane_busy[1])
  );

  simd_lane_alu #(.LANE_W(L2_W)) u_lane2 (
    .clk_i, .rst_n_i, .flush_i, .fmt_i, .op_i,
    .in_valid_i  (lane_valid[2]),     .in_ready_o  (),
    .a_i         (lane2_a),           .b_i         (lane2_b),
    .tag_i       ('0),                .aux_i       ('0),
    .out_valid_o (),                  .out_ready_i (lane_out_ready[2]),
    .result_o    (lane2_res),         .status_o    (lane2_status),
    .tag_o       (),                  .aux_o       (),
    .busy_o      (lane_busy[2])
  );

  simd_lane_alu #(.LANE_W(L3_W)) u_lane3 (
    .clk_i, .rst_n_i, .flush_i, .fmt_i, .op_i,
    .in_valid_i  (lane_valid[3]),     .in_ready_o  (),
    .a_i         (lane3_a),           .b_i         (lane3_b),
    .tag_i       ('0),                .aux_i       ('0),
    .out_valid_o (),                  .out_ready_i (lane_out_ready[3]),
    .result_o    (lane3_res),         .status_o    (lane3_status),
    .tag_o       (),                  .aux_o       (),
    .busy_o      (lane_busy[3])
  );

  // --------------------
  // Output side
  // --------------------
  simd_result_pack u_simd_result_pack (
    .aux_i            (out_aux),
    .out_ready_i      (out_ready_i),
    .lane_out_ready_o (lane_out_ready),
    .lane0_result_i   (lane0_res),
    .lane1_result_i   (lane1_res),
    .lane2_result_i   (lane2_res),
    .lane3_result_i   (lane3_res),
    .lane0_status_i   (lane0_status),
    .lane1_status_i   (lane1_status),
    .lane2_status_i   (lane2_status),
    .lane3_status_i   (lane3_status),
    .lane_busy_i      (lane_busy),
    .result_o         (result_o),
    .status_o         (status_o),
    .ext_bit_o        (ext_bit_o),
    .busy_o           (busy_o)
  );

endmodule

//--- source/simd_result_pack.sv
// Result packing with extension fill, status collapse, ready gating and busy merge
module simd_result_pack (
  input  simd_pkg::aux_t                      aux_i,
  input  logic                                out_ready_i,
  output simd_pkg::lane_mask_t                lane_out_ready_o,
  input  simd_pkg::word_t                     lane0_result_i,
  input  logic [simd_pkg::lane_width(1)-1:0]  lane1_result_i,
  input  logic [simd_pkg::lane_width(2)-1:0]  lane2_result_i,
  input  logic [simd_pkg::lane_width(3)-1:0]  lane3_result_i,
  input  simd_pkg::status_t                   lane0_status_i,
  input  simd_pkg::status_t                   lane1_status_i,
  input  simd_pkg::status_t                   lane2_status_i,
  input  simd_pkg::status_t                   lane3_status_i,
  input  simd_pkg::lane_mask_t                lane_busy_i,
  output simd_pkg::word_t                     result_o,
  output simd_pkg::status_t                   status_o,
  output logic                                ext_bit_o,
  output logic                                busy_o
);

  localparam int unsigned NUM_LANES = simd_pkg::NUM_LANES;

  simd_pkg::fmt_e       fmt;
  simd_pkg::lane_mask_t used_lanes;
  simd_pkg::word_t      lane_res [NUM_LANES];   // Zero-extended lane results
  simd_pkg::status_t    lane_status [NUM_LANES];

  // --------------------
  // Aux decode
  // --------------------
  assign used_lanes = aux_i[NUM_LANES-1:0];
  assign fmt        = simd_pkg::fmt_e'(aux_i[NUM_LANES +: $bits(simd_pkg::fmt_e)]);

  assign lane_res[0] = lane0_result_i;
  assign lane_res[1] = simd_pkg::word_t'(lane1_result_i);
  assign lane_res[2] = simd_pkg::word_t'(lane2_result_i);
  assign lane_res[3] = simd_pkg::word_t'(lane3_result_i);

  assign lane_status[0] = lane0_status_i;
  assign lane_status[1] = lane1_status_i;
  assign lane_status[2] = lane2_status_i;
  assign lane_status[3] = lane3_status_i;

  // Upper lanes only leave together with lane 0
  assign lane_out_ready_o = {NUM_LANES{out_ready_i}} & used_lanes;

  // Sign of lane 0's element
  assign ext_bit_o = lane0_result_i[simd_pkg::fmt_width(fmt)-1];

  // --------------------
  // Packing
  // --------------------
  always_comb begin : pack_result
    result_o = {simd_pkg::WORD_W{ext_bit_o}}; // Slots of idle lanes stay sign filled
    case (fmt)
      simd_pkg::W8: begin
        for (int unsigned i = 0; i < NUM_LANES; i++) begin
          if (used_lanes[i]) begin
            result_o[i*8 +: 8] = lane_res[i][7:0];
          end
        end
      end
      simd_pkg::W16: begin
        for (int unsigned i = 0; i < 2; i++) begin
          if (used_lanes[i]) begin
            result_o[i*16 +: 16] = lane_res[i][15:0];
          end
        end
      end
      default: result_o = lane_res[0];
    endcase
  end

  always_comb begin : collapse_status
    status_o = '0;
    for (int unsigned i = 0; i < NUM_LANES; i++) begin
      if (used_lanes[i]) begin
        status_o |= lane_status[i];
      end
    end
  end

  assign busy_o = |lane_busy_i;

endmodule

//--- source/simd_lane_alu.sv
// Execute lane with signed ADD/SUB/MIN/MAX, overflow detection and its result pipeline
module simd_lane_alu #(
  parameter int unsigned LANE_W = 32
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  simd_pkg::fmt_e      fmt_i,
  input  simd_pkg::op_e       op_i,
  input  logic [LANE_W-1:0]   a_i,
  input  logic [LANE_W-1:0]   b_i,
  input  simd_pkg::tag_t      tag_i,
  input  simd_pkg::aux_t      aux_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic [LANE_W-1:0]   result_o,
  output simd_pkg::status_t   status_o,
  output simd_pkg::tag_t      tag_o,
  output simd_pkg::aux_t      aux_o,
  output logic                busy_o
);

  localparam int unsigned PIPE_W = LANE_W + $bits(simd_pkg::status_t) +
                                   $bits(simd_pkg::tag_t) + $bits(simd_pkg::aux_t);

  int unsigned        elem_w;
  int unsigned        shamt;
  logic [LANE_W-1:0]  a_al, b_al;  // Element moved up so its sign sits on the top bit
  logic [LANE_W-1:0]  b_add, sum;
  logic [LANE_W-1:0]  res_al, res;
  logic               is_sub, is_arith, a_lt_b;
  logic               pos_ovf, neg_ovf;
  simd_pkg::status_t  status;
  logic [PIPE_W-1:0]  pipe_in, pipe_out;

  // --------------------
  // Element alignment
  // --------------------
  always_comb begin : elem_size
    elem_w = simd_pkg::fmt_width(fmt_i);
    if (elem_w > LANE_W) begin
      elem_w = LANE_W; // Capped by what this lane can hold
    end
    shamt = LANE_W - elem_w;
  end

  assign a_al = a_i << shamt;
  assign b_al = b_i << shamt;

  // --------------------
  // Arithmetic
  // --------------------
  assign is_sub   = (op_i == simd_pkg::SUB);
  assign is_arith = (op_i == simd_pkg::ADD) || is_sub;
  assign b_add    = is_sub ? ~b_al : b_al;
  assign sum      = a_al + b_add + LANE_W'(is_sub); // Carry in lands on the element's LSB
  assign a_lt_b   = $signed(a_al) < $signed(b_al);

  always_comb begin : op_select
    case (op_i)
      simd_pkg::MIN: res_al = a_lt_b ? a_al : b_al;
      simd_pkg::MAX: res_al = a_lt_b ? b_al : a_al;
      default:       res_al = sum;
    endcase
  end

  // Back down to the element, sign filling the lane
  assign res = $signed(res_al) >>> shamt;

  // Same operand signs but result sign flipped
  assign pos_ovf = is_arith & ~a_al[LANE_W-1] & ~b_add[LANE_W-1] &  sum[LANE_W-1];
  assign neg_ovf = is_arith &  a_al[LANE_W-1] &  b_add[LANE_W-1] & ~sum[LANE_W-1];
  assign status  = {pos_ovf, neg_ovf};

  // --------------------
  // Lane pipeline
  // --------------------
  assign pipe_in = {res, status, tag_i, aux_i};

  simd_lane_pipe #(
    .DATA_W (PIPE_W)
  ) u_simd_lane_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .data_i      (pipe_in),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .data_o      (pipe_out),
    .busy_o      (busy_o)
  );

  assign {result_o, status_o, tag_o, aux_o} = pipe_out;

endmodule

//--- source/simd_lane_pipe.sv
// Valid/ready register pipeline with flush and busy indication
module simd_lane_pipe #(
  parameter int unsigned DATA_W = 8
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  logic [DATA_W-1:0] data_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output logic [DATA_W-1:0] data_o,
  output logic              busy_o
);

  localparam int unsigned NUM_REGS = simd_pkg::NUM_PIPE_REGS;

  // Index i is the item after i register stages
  logic [DATA_W-1:0]   stage_data [NUM_REGS+1];
  logic [NUM_REGS:0]   stage_valid;
  logic [NUM_REGS:0]   stage_ready; // Combinational, travels backwards

  assign stage_data[0]  = data_i;
  assign stage_valid[0] = in_valid_i;

  for (genvar i = 0; i < NUM_REGS; i++) begin : gen_stage
    logic load; // Valid item actually moving into the next stage

    // Advance when the next stage moves on or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    assign load           = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        stage_valid[i+1] <= 1'b0; // Drop everything in flight
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  // --------------------
  // Ends of the chain
  // --------------------
  assign stage_ready[NUM_REGS] = out_ready_i;
  assign in_ready_o            = stage_ready[0];
  assign out_valid_o           = stage_valid[NUM_REGS];
  assign data_o                = stage_data[NUM_REGS];

  assign busy_o = |stage_valid[NUM_REGS:1]; // Anything held in a register
endmodule

//--- source/simd_operand_decode.sv
// Instruction decode into used-lane mask, lane valids, per-lane operand slices and aux data
module simd_operand_decode (
  input  logic                                     in_valid_i,
  input  logic                                     vectorial_i,
  input  simd_pkg::fmt_e                           fmt_i,
  input  simd_pkg::word_t                          op_a_i,
  input  simd_pkg::word_t                          op_b_i,
  output simd_pkg::lane_mask_t                     lane_valid_o,
  output simd_pkg::word_t                          lane0_a_o,
  output simd_pkg::word_t                          lane0_b_o,
  output logic [simd_pkg::lane_width(1)-1:0]       lane1_a_o,
  output logic [simd_pkg::lane_width(1)-1:0]       lane1_b_o,
  output logic [simd_pkg::lane_width(2)-1:0]       lane2_a_o,
  output logic [simd_pkg::lane_width(2)-1:0]       lane2_b_o,
  output logic [simd_pkg::lane_width(3)-1:0]       lane3_a_o,
  output logic [simd_pkg::lane_width(3)-1:0]       lane3_b_o,
  output simd_pkg::aux_t                           aux_o
);

  localparam int unsigned NUM_LANES = simd_pkg::NUM_LANES;

  simd_pkg::lane_mask_t used_lanes;
  simd_pkg::word_t      a_shifted [NUM_LANES]; // Operand words moved down to each lane's slot
  simd_pkg::word_t      b_shifted [NUM_LANES];
  int unsigned          elem_w;

  // --------------------
  // Lane selection
  // --------------------
  always_comb begin : lane_select
    elem_w = simd_pkg::fmt_width(fmt_i);
    for (int unsigned i = 0; i < NUM_LANES; i++) begin
      // Lane 0 always works, upper lanes only for vectors whose element fits
      used_lanes[i] = (i == 0) ||
                      (vectorial_i &&
                       (simd_pkg::lane_width(i) >= elem_w) &&
                       ((i + 1) * elem_w <= simd_pkg::WORD_W));
      a_shifted[i]  = op_a_i >> (i * elem_w);
      b_shifted[i]  = op_b_i >> (i * elem_w);
    end
  end

  assign lane_valid_o = {NUM_LANES{in_valid_i}} & used_lanes;

  // --------------------
  // Operand slices
  // --------------------
  // Bits above the element are ignored inside each lane
  assign lane0_a_o = a_shifted[0];
  assign lane0_b_o = b_shifted[0];
  assign lane1_a_o = a_shifted[1][simd_pkg::lane_width(1)-1:0];
  assign lane1_b_o = b_shifted[1][simd_pkg::lane_width(1)-1:0];
  assign lane2_a_o = a_shifted[2][simd_pkg::lane_width(2)-1:0];
  assign lane2_b_o = b_shifted[2][simd_pkg::lane_width(2)-1:0];
  assign lane3_a_o = a_shifted[3][simd_pkg::lane_width(3)-1:0];
  assign lane3_b_o = b_shifted[3][simd_pkg::lane_width(3)-1:0];

  // Format and mask ride along lane 0 to the packer
  assign aux_o = {fmt_i, used_lanes};

endmodule

//--- source/simd_pkg.sv
// Shared widths, types, format/operation enums and lane geometry helpers for the SIMD slice
package simd_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned WORD_W        = 32;
  localparam int unsigned NUM_LANES     = 4;
  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned TAG_W         = 4;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [NUM_LANES-1:0] lane_mask_t; // One bit per lane taking part
  typedef logic [TAG_W-1:0]     tag_t;

  // Bit 1 is positive overflow, bit 0 negative overflow
  typedef logic [1:0] status_t;

  // --------------------
  // Encodings
  // --------------------
  typedef enum logic [1:0] {
    W8  = 2'd0,
    W16 = 2'd1,
    W32 = 2'd2
  } fmt_e;

  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    MIN = 2'd2,
    MAX = 2'd3
  } op_e;

  // Format on top, used-lane mask below
  typedef logic [$bits(fmt_e)+NUM_LANES-1:0] aux_t;

  // --------------------
  // Lane geometry
  // --------------------
  function automatic int unsigned fmt_width(fmt_e fmt);
    case (fmt)
      W8:      return 8;
      W16:     return 16;
      default: return WORD_W; // Unused code treated as a full word
    endcase
  endfunction

  // Widest element whose slot for lane i still fits in the word
  function automatic int unsigned lane_width(int unsigned lane);
    if (lane == 0) begin
      return WORD_W;
    end else if (lane == 1) begin
      return WORD_W / 2;
    end else begin
      return WORD_W / 4;
    end
  endfunction

endpackage
